// ==== design/icache_config.svh ====
// Cache and bus geometry for the instruction cache
// and the base of the non-cacheable address range
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Byte address width of fetch and bus addresses
`define ICACHE_ADDR_WIDTH 32

// Direct-mapped geometry
`define ICACHE_LINE_WIDTH 128
`define ICACHE_NUM_SETS   16

// Read channel
`define BUS_DATA_WIDTH 32
`define BUS_ID_WIDTH   4

// R beats needed to fill one line
`define ICACHE_LINE_BEATS (`ICACHE_LINE_WIDTH / `BUS_DATA_WIDTH)

// Everything at or above this address bypasses the cache
`define ICACHE_NC_BASE 32'h8000_0000

`endif

// ==== design/icache_pkg.sv ====
// Packed structs shared by the instruction cache, the read shim
// and the refill buffer
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

  // One cache line seen as bus-sized words, word 0 at the lowest address
  typedef logic [`ICACHE_LINE_BEATS-1:0][`BUS_DATA_WIDTH-1:0] cache_line_t;

  // Fetch port
  typedef struct packed {
    logic                          valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                          ready;
    logic                          valid;
    logic [`BUS_DATA_WIDTH-1:0]    data;
    logic [`ICACHE_ADDR_WIDTH-1:0] addr;
  } fetch_rsp_t;

  // Core to read shim
  typedef struct packed {
    logic [`ICACHE_ADDR_WIDTH-1:0] paddr;
    logic                          nc;
    logic [`BUS_ID_WIDTH-1:0]      tid;
  } miss_req_t;

  // Refill buffer to core
  typedef struct packed {
    cache_line_t              data;
    logic [`BUS_ID_WIDTH-1:0] tid;
  } line_rtrn_t;

  // Simplified AXI read channel, AR and R only
  typedef struct packed {
    logic                          ar_valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] ar_addr;
    logic [7:0]                    ar_len;
    logic [`BUS_ID_WIDTH-1:0]      ar_id;
    logic                          r_ready;
  } axi_rd_req_t;

  typedef struct packed {
    logic                       ar_ready;
    logic                       r_valid;
    logic [`BUS_DATA_WIDTH-1:0] r_data;
    logic                       r_last;
    logic [`BUS_ID_WIDTH-1:0]   r_id;
  } axi_rd_rsp_t;

endpackage

`default_nettype wire

// ==== design/icache_core.sv ====
// Direct-mapped instruction cache core: tag, valid and data arrays,
// hit/miss decision, fetch response and miss request
`default_nettype none
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_core
  import icache_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             en_i,
  input  wire             flush_i,
  input  wire fetch_req_t fetch_req_i,
  output fetch_rsp_t      fetch_rsp_o,
  output logic            miss_valid_o,
  output miss_req_t       miss_req_o,
  input  wire             line_valid_i,
  input  wire line_rtrn_t line_rtrn_i,
  output logic            miss_o,
  output logic            busy_o
);

  localparam int ADDR_W   = `ICACHE_ADDR_WIDTH;
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_WIDTH / 8);
  localparam int INDEX_W  = $clog2(`ICACHE_NUM_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_LSB = $clog2(`BUS_DATA_WIDTH / 8);
  localparam int WSEL_W   = $clog2(`ICACHE_LINE_BEATS);

  // All refills from this cache use one id
  localparam logic [`BUS_ID_WIDTH-1:0] RD_TID = '0;

  typedef enum logic [1:0] {IDLE, HIT_RSP, WAIT_REFILL, FLUSHING} state_e;

  state_e state_q, state_d;

  logic [`ICACHE_NUM_SETS-1:0] valid_q, valid_d;
  logic [TAG_W-1:0]            tag_q  [`ICACHE_NUM_SETS];
  cache_line_t                 data_q [`ICACHE_NUM_SETS];

  logic [ADDR_W-1:0]          req_addr_q;
  logic                       req_nc_q;
  logic [`BUS_DATA_WIDTH-1:0] rsp_data_q;
  logic                       miss_valid_q;

  logic [INDEX_W-1:0] req_idx, fill_idx;
  logic [TAG_W-1:0]   req_tag, fill_tag;
  logic [WSEL_W-1:0]  req_wsel, fill_wsel;
  logic               rdy, accept, req_nc, req_hit, line_ok, fill_en;

  assign req_idx   = fetch_req_i.addr[OFFSET_W +: INDEX_W];
  assign req_tag   = fetch_req_i.addr[ADDR_W-1 -: TAG_W];
  assign req_wsel  = fetch_req_i.addr[WORD_LSB +: WSEL_W];
  assign fill_idx  = req_addr_q[OFFSET_W +: INDEX_W];
  assign fill_tag  = req_addr_q[ADDR_W-1 -: TAG_W];
  assign fill_wsel = req_addr_q[WORD_LSB +: WSEL_W];

  // New requests are taken while idle or while a hit is being answered
  assign rdy    = (state_q == IDLE || state_q == HIT_RSP) && !flush_i;
  assign accept = fetch_req_i.valid && rdy;

  // Disabled cache behaves like a non-cacheable region
  assign req_nc  = !en_i || (fetch_req_i.addr >= `ICACHE_NC_BASE);
  assign req_hit = !req_nc && valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  assign line_ok = (state_q == WAIT_REFILL) && line_valid_i && (line_rtrn_i.tid == RD_TID);
  assign fill_en = line_ok && !req_nc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, HIT_RSP: begin
        if (flush_i) begin
          state_d = FLUSHING;
        end else if (accept) begin
          state_d = req_hit ? HIT_RSP : WAIT_REFILL;
        end else begin
          state_d = IDLE;
        end
      end
      WAIT_REFILL: begin
        if (line_ok) begin
          state_d = HIT_RSP;
        end
      end
      FLUSHING: begin
        if (!flush_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Flush takes priority over a line that returns in the same cycle
  always_comb begin
    valid_d = valid_q;
    if (fill_en) begin
      valid_d[fill_idx] = 1'b1;
    end
    if (flush_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      valid_q      <= '0;
      miss_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_q      <= valid_d;
      miss_valid_q <= accept && !req_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= fetch_req_i.addr;
      req_nc_q   <= req_nc;
    end
    if (accept && req_hit) begin
      rsp_data_q <= data_q[req_idx][req_wsel];
    end else if (line_ok) begin
      // A bypass burst is a single beat placed at word 0
      rsp_data_q <= req_nc_q ? line_rtrn_i.data[0] : line_rtrn_i.data[fill_wsel];
    end
    if (fill_en) begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= line_rtrn_i.data;
    end
  end

  assign fetch_rsp_o.ready = rdy;
  assign fetch_rsp_o.valid = (state_q == HIT_RSP);
  assign fetch_rsp_o.data  = rsp_data_q;
  assign fetch_rsp_o.addr  = req_addr_q;

  // Line address for a refill, word address for a bypass
  assign miss_req_o.paddr = req_nc_q ?
                            {req_addr_q[ADDR_W-1:WORD_LSB], {WORD_LSB{1'b0}}} :
                            {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign miss_req_o.nc    = req_nc_q;
  assign miss_req_o.tid   = RD_TID;
  assign miss_valid_o     = miss_valid_q;

  assign miss_o = miss_valid_q;
  assign busy_o = (state_q == WAIT_REFILL);

  // The bus only returns lines that were asked for
  a_no_line_when_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    line_valid_i |-> (state_q != IDLE)
  );

endmodule

`default_nettype wire

// ==== design/refill_buffer.sv ====
// Refill buffer: shifts R beats into a cache line and returns it
// with the transaction id on the last beat
`default_nettype none
`timescale 1ns/1ps

`include "icache_config.svh"

module refill_buffer
  import icache_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire axi_rd_rsp_t axi_rsp_i,
  output logic             line_valid_o,
  output line_rtrn_t       line_rtrn_o
);

  localparam int BEATS = `ICACHE_LINE_BEATS;

  logic                     first_q, first_d;
  cache_line_t              shift_q, shift_d;
  logic [`BUS_ID_WIDTH-1:0] id_q;

  // New beats enter at the top and move towards word 0
  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (axi_rsp_i.r_valid) begin
      first_d = axi_rsp_i.r_last;
      shift_d = {axi_rsp_i.r_data, shift_q[BEATS-1:1]};
      // Single-beat bursts must land at offset 0
      if (first_q) begin
        shift_d[0] = axi_rsp_i.r_data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
    end else begin
      first_q <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
    if (axi_rsp_i.r_valid) begin
      id_q <= axi_rsp_i.r_id;
    end
  end

  assign line_valid_o     = axi_rsp_i.r_valid && axi_rsp_i.r_last;
  assign line_rtrn_o.data = shift_d;
  assign line_rtrn_o.tid  = axi_rsp_i.r_id;

  // Beats of one burst carry one id
  a_burst_id_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (axi_rsp_i.r_valid && !first_q) |-> (axi_rsp_i.r_id == id_q)
  );

endmodule

`default_nettype wire

// ==== design/axi_read_shim.sv ====
// Read shim: holds a miss request on AR until it is accepted
// and chooses the burst length
`default_nettype none
`timescale 1ns/1ps

`include "icache_config.svh"

module axi_read_shim
  import icache_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            miss_valid_i,
  input  wire miss_req_t miss_req_i,
  output axi_rd_req_t    axi_req_o,
  input  wire            axi_ar_ready_i
);

  logic      pending_q, pending_d;
  miss_req_t req_q, req_d;

  // Request stays up until AR handshake, the core does not wait for it
  assign pending_d = !axi_ar_ready_i && (miss_valid_i || pending_q);
  assign req_d     = miss_valid_i ? miss_req_i : req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

  assign axi_req_o.ar_valid = miss_valid_i || pending_q;
  assign axi_req_o.ar_addr  = req_d.paddr;
  // Full line for a refill, one beat for a bypass
  assign axi_req_o.ar_len   = req_d.nc ? 8'd0 : 8'(`ICACHE_LINE_BEATS - 1);
  assign axi_req_o.ar_id    = req_d.tid;
  assign axi_req_o.r_ready  = 1'b1;

  a_ar_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (axi_req_o.ar_valid && !axi_ar_ready_i) |=>
      (axi_req_o.ar_valid && $stable(axi_req_o.ar_addr))
  );

  // The core keeps one miss outstanding at a time
  a_single_miss: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    miss_valid_i |-> !pending_q
  );

endmodule

`default_nettype wire

// ==== design/icache_axi_wrapper.sv ====
// Top level of the instruction cache: core, AR shim and
// refill buffer on a simplified AXI read channel
`default_nettype none
`timescale 1ns/1ps

module icache_axi_wrapper
  import icache_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire              en_i,
  input  wire              flush_i,
  input  wire fetch_req_t  fetch_req_i,
  output fetch_rsp_t       fetch_rsp_o,
  output logic             miss_o,
  output logic             busy_o,
  output axi_rd_req_t      axi_req_o,
  input  wire axi_rd_rsp_t axi_rsp_i
);

  logic       miss_valid;
  miss_req_t  miss_req;
  logic       line_valid;
  line_rtrn_t line_rtrn;

  icache_core i_icache_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .en_i         (en_i),
    .flush_i      (flush_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_rsp_o  (fetch_rsp_o),
    .miss_valid_o (miss_valid),
    .miss_req_o   (miss_req),
    .line_valid_i (line_valid),
    .line_rtrn_i  (line_rtrn),
    .miss_o       (miss_o),
    .busy_o       (busy_o)
  );

  axi_read_shim i_axi_read_shim (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .miss_valid_i   (miss_valid),
    .miss_req_i     (miss_req),
    .axi_req_o      (axi_req_o),
    .axi_ar_ready_i (axi_rsp_i.ar_ready)
  );

  refill_buffer i_refill_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .axi_rsp_i    (axi_rsp_i),
    .line_valid_o (line_valid),
    .line_rtrn_o  (line_rtrn)
  );

endmodule

`default_nettype wire

// ==== testbench/axi_mem_model.sv ====
// Read-only memory on the simplified AXI read channel, data derived
// from the address, AR acceptance and beat gaps driven from outside
`default_nettype none
`timescale 1ns/1ps

`include "icache_config.svh"

module axi_mem_model
  import icache_pkg::*;
(
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire axi_rd_req_t axi_req_i,
  output axi_rd_rsp_t      axi_rsp_o,
  input  wire              ar_ready_en_i,
  input  wire              beat_en_i
);

  // Word at byte address A reads as A xor this pattern
  localparam logic [`BUS_DATA_WIDTH-1:0] DATA_XOR = 32'h5a5a_0000;

  logic                          busy_q;
  logic [`ICACHE_ADDR_WIDTH-1:0] addr_q;
  logic [7:0]                    len_q;
  logic [7:0]                    cnt_q;
  logic [`BUS_ID_WIDTH-1:0]      id_q;
  logic [`ICACHE_ADDR_WIDTH-1:0] beat_addr;

  // One burst at a time, so AR is only offered while idle
  assign axi_rsp_o.ar_ready = !busy_q && ar_ready_en_i;
  assign axi_rsp_o.r_valid  = busy_q && beat_en_i;
  assign beat_addr          = addr_q + (32'(cnt_q) << 2);
  assign axi_rsp_o.r_data   = beat_addr ^ DATA_XOR;
  assign axi_rsp_o.r_last   = (cnt_q == len_q);
  assign axi_rsp_o.r_id     = id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      addr_q <= '0;
      len_q  <= '0;
      cnt_q  <= '0;
      id_q   <= '0;
    end else if (!busy_q) begin
      if (axi_req_i.ar_valid && axi_rsp_o.ar_ready) begin
        busy_q <= 1'b1;
        addr_q <= axi_req_i.ar_addr;
        len_q  <= axi_req_i.ar_len;
        id_q   <= axi_req_i.ar_id;
        cnt_q  <= '0;
      end
    end else if (axi_rsp_o.r_valid && axi_req_i.r_ready) begin
      if (cnt_q == len_q) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_icache_axi_wrapper.sv ====
// Testbench for the instruction cache wrapper: stimulus table, random
// bus stalls from an LFSR, value checks, timeout and summary
`default_nettype none
`timescale 1ns/1ps

`include "icache_config.svh"

module tb_icache_axi_wrapper
  import icache_pkg::*;
();

  localparam int          CLK_PERIOD     = 100;
  localparam int          RESET_CYCLES   = 4;
  localparam int          NUM_ROWS       = 24;
  localparam int          CYCLES_PER_ROW = 64;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES;
  localparam logic [31:0] MEM_XOR        = 32'h5a5a_0000;
  localparam logic [31:0] LFSR_SEED      = 32'hba5e;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  typedef enum logic [2:0] {OP_IDLE_CHK, OP_FETCH, OP_FLUSH, OP_EN_OFF, OP_EN_ON} op_e;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        en_i;
  logic        flush_i;
  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  logic        miss;
  logic        busy;
  axi_rd_req_t axi_req;
  axi_rd_rsp_t axi_rsp;
  logic        ar_ready_en = 1'b0;
  logic        beat_en     = 1'b0;
  logic [31:0] lfsr_q      = LFSR_SEED;
  int          cycle_count = 0;

  // Stimulus table
  string       row_name [NUM_ROWS];
  op_e         row_op   [NUM_ROWS];
  logic [31:0] row_addr [NUM_ROWS];
  logic        row_miss [NUM_ROWS];
  int          row_count;

  int row_errors;
  int tests_passed;
  int tests_failed;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  icache_axi_wrapper uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .en_i        (en_i),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req),
    .fetch_rsp_o (fetch_rsp),
    .miss_o      (miss),
    .busy_o      (busy),
    .axi_req_o   (axi_req),
    .axi_rsp_i   (axi_rsp)
  );

  axi_mem_model i_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .axi_req_i     (axi_req),
    .axi_rsp_o     (axi_rsp),
    .ar_ready_en_i (ar_ready_en),
    .beat_en_i     (beat_en)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  // Memory contents as seen from the fetch side
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_XOR;
  endfunction

  // Two random bits per cycle for AR acceptance and beat presence
  always @(negedge clk_i) begin
    ar_ready_en = lfsr_q[0];
    lfsr_q      = lfsr_next(lfsr_q);
    beat_en     = lfsr_q[0];
    lfsr_q      = lfsr_next(lfsr_q);
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic add_row(input string name, input op_e op, input logic [31:0] addr,
                         input logic exp_miss);
    row_name[row_count] = name;
    row_op[row_count]   = op;
    row_addr[row_count] = addr;
    row_miss[row_count] = exp_miss;
    row_count++;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s %s expected %08h actual %08h", name, what, expected, actual);
      row_errors++;
    end
  endtask

  // Issue one fetch, wait for its response and count miss pulses on the way
  task automatic run_fetch(input string name, input logic [31:0] addr, input logic exp_miss);
    int   misses;
    int   waited;
    int   ready_high;
    logic seen_ready;
    logic seen_busy;
    misses          = 0;
    waited          = 0;
    ready_high      = 0;
    seen_busy       = 1'b0;
    fetch_req.valid = 1'b1;
    fetch_req.addr  = addr;
    seen_ready      = fetch_rsp.ready;
    while (!seen_ready) begin
      @(negedge clk_i);
      seen_ready = fetch_rsp.ready;
    end
    @(negedge clk_i);
    fetch_req.valid = 1'b0;
    while (!fetch_rsp.valid) begin
      if (miss) begin
        misses++;
      end
      if (busy) begin
        seen_busy = 1'b1;
      end
      if (fetch_rsp.ready) begin
        ready_high++;
      end
      waited++;
      @(negedge clk_i);
    end
    check_value(name, "miss_o pulses", 32'(exp_miss), 32'(misses));
    check_value(name, "busy_o seen", 32'(exp_miss), 32'(seen_busy));
    check_value(name, "ready while waiting", 32'd0, 32'(ready_high));
    if (!exp_miss) begin
      // A hit answers one cycle after it is accepted
      check_value(name, "hit wait cycles", 32'd0, 32'(waited));
    end
    check_value(name, "data", mem_word(addr), fetch_rsp.data);
    check_value(name, "addr", addr, fetch_rsp.addr);
  endtask

  task automatic run_flush(input string name);
    flush_i = 1'b1;
    @(negedge clk_i);
    check_value(name, "ready during flush", 32'd0, 32'(fetch_rsp.ready));
    check_value(name, "busy during flush", 32'd0, 32'(busy));
    flush_i = 1'b0;
  endtask

  task automatic check_idle(input string name);
    check_value(name, "ar_valid", 32'd0, 32'(axi_req.ar_valid));
    check_value(name, "rsp valid", 32'd0, 32'(fetch_rsp.valid));
    check_value(name, "miss_o", 32'd0, 32'(miss));
    check_value(name, "busy_o", 32'd0, 32'(busy));
    check_value(name, "ready", 32'd1, 32'(fetch_rsp.ready));
  endtask

  initial begin
    rst_ni       = 1'b0;
    en_i         = 1'b1;
    flush_i      = 1'b0;
    fetch_req    = '0;
    row_count    = 0;
    tests_passed = 0;
    tests_failed = 0;

    add_row("reset_values", OP_IDLE_CHK, 32'h0, 1'b0);
    add_row("cold_miss_w0", OP_FETCH, 32'h0000_1000, 1'b1);
    add_row("hit_w1", OP_FETCH, 32'h0000_1004, 1'b0);
    add_row("hit_w2", OP_FETCH, 32'h0000_1008, 1'b0);
    add_row("hit_w3", OP_FETCH, 32'h0000_100c, 1'b0);
    add_row("hit_w0", OP_FETCH, 32'h0000_1000, 1'b0);
    // Bypass region returns a single beat at word 0
    add_row("nc_first", OP_FETCH, `ICACHE_NC_BASE + 32'h10, 1'b1);
    add_row("nc_repeat", OP_FETCH, `ICACHE_NC_BASE + 32'h10, 1'b1);
    add_row("nc_odd_word", OP_FETCH, `ICACHE_NC_BASE + 32'h1c, 1'b1);
    add_row("flush", OP_FLUSH, 32'h0, 1'b0);
    add_row("refetch_after_flush", OP_FETCH, 32'h0000_1008, 1'b1);
    add_row("hit_after_refill", OP_FETCH, 32'h0000_100c, 1'b0);
    add_row("cache_off", OP_EN_OFF, 32'h0, 1'b0);
    add_row("off_cached_line", OP_FETCH, 32'h0000_1004, 1'b1);
    add_row("off_cached_again", OP_FETCH, 32'h0000_1004, 1'b1);
    add_row("off_new_line", OP_FETCH, 32'h0000_2030, 1'b1);
    add_row("cache_on", OP_EN_ON, 32'h0, 1'b0);
    add_row("on_not_allocated", OP_FETCH, 32'h0000_2030, 1'b1);
    add_row("on_hit", OP_FETCH, 32'h0000_2034, 1'b0);
    // Two tags that share set 5
    add_row("evict_a", OP_FETCH, 32'h0000_3050, 1'b1);
    add_row("evict_b", OP_FETCH, 32'h0000_4050, 1'b1);
    add_row("evict_a_again", OP_FETCH, 32'h0000_3058, 1'b1);
    add_row("evict_b_again", OP_FETCH, 32'h0000_405c, 1'b1);
    add_row("alias_hit", OP_FETCH, 32'h0000_4054, 1'b0);

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < row_count; i++) begin
      row_errors = 0;
      case (row_op[i])
        OP_IDLE_CHK: check_idle(row_name[i]);
        OP_FETCH:    run_fetch(row_name[i], row_addr[i], row_miss[i]);
        OP_FLUSH:    run_flush(row_name[i]);
        OP_EN_OFF: begin
          en_i = 1'b0;
          @(negedge clk_i);
        end
        OP_EN_ON: begin
          en_i = 1'b1;
          @(negedge clk_i);
        end
        default: begin
          $display("Unknown operation in table row %0d", i);
          row_errors++;
        end
      endcase
      if (row_errors == 0) begin
        tests_passed++;
        $display("PASS %s", row_name[i]);
      end else begin
        tests_failed++;
        $display("FAIL %s", row_name[i]);
      end
    end

    $display("Tests: %0d passed, %0d failed of %0d", tests_passed, tests_failed, row_count);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_axi.f ====
+incdir+design
design/icache_pkg.sv
design/icache_core.sv
design/refill_buffer.sv
design/axi_read_shim.sv
design/icache_axi_wrapper.sv
testbench/axi_mem_model.sv
testbench/tb_icache_axi_wrapper.sv
